/* build.f */
rtl/ttl_pkg.sv
rtl/board_pkg.sv
rtl/ttl_161.sv
rtl/ttl_2016.sv
rtl/video_timing.sv
rtl/vram_arbiter.sv
rtl/pixel_shifter.sv
rtl/tile_scan_top.sv
dv/tile_scan_sva.sv
dv/tile_scan_tb.sv

/* Bender.yml */
package:
  name: tile_scan

sources:
  - files:
      - rtl/ttl_pkg.sv
      - rtl/board_pkg.sv
      - rtl/ttl_161.sv
      - rtl/ttl_2016.sv
      - rtl/video_timing.sv
      - rtl/vram_arbiter.sv
      - rtl/pixel_shifter.sv
      - rtl/tile_scan_top.sv
  - target: simulation
    files:
      - dv/tile_scan_sva.sv
      - dv/tile_scan_tb.sv

/* dv/tile_scan_tb.sv */
`default_nettype none

module tile_scan_tb
    import ttl_pkg::*, board_pkg::*;
();

    localparam int HALF_PERIOD   = 20;                 // 40 per clock
    localparam int RESET_CYCLES  = 16;
    localparam int DRIVE_DELAY   = 5;                  // after rising edge
    localparam int SEED          = 37;
    localparam int TABLE_ROWS    = 12;
    localparam int RAND_ROWS     = 4;
    localparam int FRAME_CLKS    = H_TOTAL * V_TOTAL;
    localparam int WATCHDOG_CLKS = (4 + TABLE_ROWS + RAND_ROWS) * FRAME_CLKS; // a row may take a frame

    logic       clk;
    logic       cl_b;
    tile_addr_t cpu_addr;
    pattern_t   cpu_pattern;
    color_t     cpu_color;
    logic       cpu_we;
    logic       cpu_wait;
    byte_t      h_cnt;
    nibble_t    v_cnt;
    logic       hsync;
    logic       hblank;
    logic       vblank;
    color_t     pixel;

    int errors = 0;
    int checks = 0;
    int tests  = 0;

    pattern_t model_pat [2**$bits(tile_addr_t)]; // what the pattern ram should hold
    color_t   model_col [2**$bits(tile_addr_t)];

    // {line, column, pattern, colour, expect wait}
    logic [19:0] table_rows [TABLE_ROWS] = '{
        {4'd0,  3'd0, 8'hF0, 4'h1, 1'b1},
        {4'd0,  3'd5, 8'h81, 4'h2, 1'b0},
        {4'd1,  3'd2, 8'hAA, 4'h3, 1'b1},
        {4'd2,  3'd3, 8'h55, 4'h4, 1'b0},
        {4'd3,  3'd1, 8'hFF, 4'h5, 1'b0},
        {4'd4,  3'd4, 8'h0F, 4'h6, 1'b1},
        {4'd5,  3'd0, 8'hC3, 4'h7, 1'b0},
        {4'd6,  3'd5, 8'h3C, 4'h8, 1'b1},
        {4'd7,  3'd2, 8'h01, 4'h9, 1'b0},
        {4'd9,  3'd3, 8'h80, 4'hA, 1'b1},
        {4'd10, 3'd1, 8'h99, 4'hB, 1'b0},
        {4'd11, 3'd5, 8'h66, 4'hF, 1'b1}
    };
    logic [19:0] rows [$];                     // table plus random tail

    tile_scan_top dut (
        .clk(clk), .cl_b(cl_b), .cpu_addr(cpu_addr), .cpu_pattern(cpu_pattern),
        .cpu_color(cpu_color), .cpu_we(cpu_we), .cpu_wait(cpu_wait), .h_cnt(h_cnt),
        .v_cnt(v_cnt), .hsync(hsync), .hblank(hblank), .vblank(vblank), .pixel(pixel)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CLKS + RESET_CYCLES) @(posedge clk);
        $display("timed out: run still going after %0d clocks", WATCHDOG_CLKS + RESET_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // one compare task per result type

    task automatic color_check(input color_t got, input color_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic byte_check(input byte_t got, input byte_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic nibble_check(input nibble_t got, input nibble_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic bit_check(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        $display("test %-12s %s", name, (errors == errs_before) ? "ok" : "mismatch");
    endtask

    ////////////////////////////////////////////////////////////
    // reference model

    // msb of the pattern byte is the leftmost pixel of the tile
    function automatic color_t expect_pixel(input int h, input int v);
        tile_addr_t a;
        pattern_t   p;
        a = {v[3:0], 3'(h / TILE_W)};
        p = model_pat[a];
        return p[TILE_W - 1 - (h % TILE_W)] ? model_col[a] : color_t'(0);
    endfunction

    // park the beam in active video or early vblank
    task automatic wait_beam(input logic active);
        logic ok;
        ok = 1'b0;
        while (!ok) begin
            @(negedge clk);
            if (active) ok = (v_cnt < V_VISIBLE - 1);         // room before vblank
            else ok = (v_cnt >= V_VISIBLE) && (v_cnt < V_TOTAL - 1);
        end
    endtask

    // hold the write until cpu_wait is seen low
    task automatic write_tile(input tile_addr_t a, input pattern_t p, input color_t c,
                              output logic waited);
        logic done;
        waited = 1'b0;
        done   = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
        cpu_addr    = a;
        cpu_pattern = p;
        cpu_color   = c;
        cpu_we      = 1'b1;
        while (!done) begin
            @(negedge clk);
            bit_check(cpu_wait, v_cnt < V_VISIBLE, "cpu_wait"); // stalls only in active video
            if (cpu_wait) waited = 1'b1;
            else done = 1'b1;
        end
        @(posedge clk);                       // write lands on this edge
        #DRIVE_DELAY;
        cpu_we       = 1'b0;
        model_pat[a] = p;
        model_col[a] = c;
    endtask

    // one whole frame from h 0 v 0 sampled mid cycle
    task automatic scan_frame(input string name, input logic pix_on);
        int e0;
        e0 = errors;
        @(negedge clk);
        while (h_cnt != 0 || v_cnt != 0) @(negedge clk);
        for (int v = 0; v < V_TOTAL; v++) begin
            for (int h = 0; h < H_TOTAL; h++) begin
                if (h != 0 || v != 0) @(negedge clk);
                byte_check(h_cnt, byte_t'(h), "h_cnt");
                nibble_check(v_cnt, nibble_t'(v), "v_cnt");
                bit_check(hblank, h >= H_VISIBLE, "hblank");
                bit_check(hsync, (h >= HSYNC_START) && (h < HSYNC_END), "hsync");
                bit_check(vblank, v >= V_VISIBLE, "vblank");
                if (pix_on && v < V_VISIBLE && h >= PIXEL_LATENCY &&
                    h < H_VISIBLE + PIXEL_LATENCY) begin
                    color_check(pixel, expect_pixel(h - PIXEL_LATENCY, v),
                                $sformatf("pixel h%0d v%0d", h - PIXEL_LATENCY, v));
                end
            end
        end
        finish_test(name, e0);
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        logic [19:0] row;
        logic        waited;
        int          e0;
        cl_b        = 1'b0;
        cpu_addr    = '0;
        cpu_pattern = '0;
        cpu_color   = '0;
        cpu_we      = 1'b0;
        void'($urandom(SEED));

        e0 = errors;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            color_check(pixel, '0, "pixel in reset");
            bit_check(hsync, 1'b0, "hsync in reset");
            bit_check(hblank, 1'b0, "hblank in reset");
            byte_check(h_cnt, '0, "h_cnt in reset");
            nibble_check(v_cnt, '0, "v_cnt in reset");
        end
        @(posedge clk);
        #DRIVE_DELAY;
        cl_b = 1'b1;
        finish_test("reset", e0);
        scan_frame("raster", 1'b0);           // rams still unknown

        e0 = errors;
        for (int v = 0; v < V_VISIBLE; v++) begin
            for (int c = 0; c < H_VISIBLE / TILE_W; c++) begin
                write_tile({4'(v), 3'(c)}, '0, '0, waited);
            end
        end
        finish_test("clear", e0);

        foreach (table_rows[i]) rows.push_back(table_rows[i]);
        repeat (RAND_ROWS) begin
            rows.push_back({4'($urandom_range(V_VISIBLE - 1)),
                            3'($urandom_range(H_VISIBLE / TILE_W - 1)),
                            8'($urandom), 4'($urandom), 1'b0});
        end
        for (int i = 0; i < rows.size(); i++) begin
            e0  = errors;
            row = rows[i];
            wait_beam(row[0]);                // wait rows start in active video
            write_tile(row[19:13], row[12:5], row[4:1], waited);
            bit_check(waited, row[0], $sformatf("row %0d wait seen", i));
            finish_test($sformatf("row %0d", i), e0);
        end
        scan_frame("readout", 1'b1);

        // one tile rewritten in vblank
        e0 = errors;
        wait_beam(1'b0);
        write_tile({4'd1, 3'd2}, 8'h18, 4'hE, waited);
        bit_check(waited, 1'b0, "overwrite wait seen");
        finish_test("rewrite", e0);
        scan_frame("overwrite", 1'b1);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/tile_scan_sva.sv */
`default_nettype none

module tile_scan_sva (
    input wire logic clk,
    input wire logic cl_b,
    input wire logic cpu_we,
    input wire logic cpu_wait,
    input wire logic hsync,
    input wire logic hblank,
    input wire logic vblank
);

    ////////////////////////////////////////////////////////////
    // raster windows

    property sync_in_blank;
        @(posedge clk) disable iff (!cl_b) hsync |-> hblank;       // sync sits in border
    endproperty

    property sync_width;
        @(posedge clk) disable iff (!cl_b)
            $rose(hsync) |-> hsync [*4] ##1 !hsync;                 // 4 clock pulse
    endproperty

    ////////////////////////////////////////////////////////////
    // cpu write rule

    property wait_in_active;
        @(posedge clk) disable iff (!cl_b) (cpu_we && !vblank) |-> cpu_wait;
    endproperty

    property no_wait_in_vblank;
        @(posedge clk) disable iff (!cl_b) vblank |-> !cpu_wait;  // rams free for cpu
    endproperty

    a_sync_in_blank:     assert property (sync_in_blank) else $error("hsync outside hblank");
    a_sync_width:        assert property (sync_width) else $error("hsync pulse not 4 clocks");
    a_wait_in_active:    assert property (wait_in_active) else $error("write not stalled");
    a_no_wait_in_vblank: assert property (no_wait_in_vblank) else $error("stall in vblank");

endmodule

bind tile_scan_top tile_scan_sva u_sva (
    .clk(clk), .cl_b(cl_b), .cpu_we(cpu_we), .cpu_wait(cpu_wait),
    .hsync(hsync), .hblank(hblank), .vblank(vblank)
);

`default_nettype wire

/* rtl/tile_scan_top.sv */
`default_nettype none

module tile_scan_top import ttl_pkg::*, board_pkg::*; (
    input  wire logic       clk,
    input  wire logic       cl_b,        // board reset
    input  wire tile_addr_t cpu_addr,    // tile to write
    input  wire pattern_t   cpu_pattern, // to pattern ram
    input  wire color_t     cpu_color,   // to colour ram
    input  wire logic       cpu_we,      // held until wait drops
    output logic            cpu_wait,
    output byte_t           h_cnt,
    output nibble_t         v_cnt,
    output logic            hsync,
    output logic            hblank,
    output logic            vblank,
    output color_t          pixel        // video out
);

    ram_addr_t ram_addr; // shared address bus
    logic      ram_we;   // shared write strobe
    pattern_t  pat_q;    // pattern ram data out
    color_t    col_q;    // colour ram data out

    ////////////////////////////////////////////////////////////
    // timing and bus arbitration

    video_timing u_timing (
        .clk(clk), .cl_b(cl_b), .h_cnt(h_cnt), .v_cnt(v_cnt),
        .hsync(hsync), .hblank(hblank), .vblank(vblank)
    );

    vram_arbiter u_arb (
        .h_cnt(h_cnt), .v_cnt(v_cnt), .vblank(vblank),
        .cpu_addr(cpu_addr), .cpu_we(cpu_we),
        .ram_addr(ram_addr), .ram_we(ram_we), .cpu_wait(cpu_wait)
    );

    ////////////////////////////////////////////////////////////
    // tile rams, one address for both

    ttl_2016 #(.data_t(pattern_t)) pattern_ram (
        .clk(clk), .addr(ram_addr), .we(ram_we), .wdata(cpu_pattern), .rdata(pat_q)
    );

    ttl_2016 #(.data_t(color_t)) color_ram (
        .clk(clk), .addr(ram_addr), .we(ram_we), .wdata(cpu_color), .rdata(col_q)
    );

    // serialiser and output latch
    pixel_shifter u_shift (
        .clk(clk), .cl_b(cl_b), .h_cnt(h_cnt),
        .pattern(pat_q), .color(col_q), .pixel(pixel)
    );

endmodule

`default_nettype wire

/* rtl/pixel_shifter.sv */
`default_nettype none

module pixel_shifter import ttl_pkg::*, board_pkg::*; (
    input  wire logic     clk,
    input  wire logic     cl_b,    // board reset
    input  wire byte_t    h_cnt,   // beam column
    input  wire pattern_t pattern, // pattern ram output
    input  wire color_t   color,   // colour ram output
    output color_t        pixel    // to the dac
);

    logic [$clog2(TILE_W)-1:0] phase; // clock within the tile
    logic [1:0] s;            // 194 mode pins s1,s0
    logic       load;         // parallel load this clock
    pattern_t   sreg;         // 194 contents
    color_t     held_col;     // tile colour, kept across shifts
    logic       sout;         // bit leaving the shifter
    color_t     cur_col;      // colour for that bit
    color_t     pix_d;        // 273 d inputs

    ////////////////////////////////////////////////////////////
    // 194 shift register

    // rams are valid one clock into the tile
    assign phase = h_cnt[$clog2(TILE_W)-1:0];
    assign s     = (phase == $bits(phase)'(1)) ? 2'b11 : 2'b01; // load or shift left
    assign load  = (s == 2'b11);

    always_ff @(posedge clk or negedge cl_b) begin
        if (!cl_b) begin
            sreg <= '0;
        end else begin
            case (s)
                2'b11:   sreg <= {pattern[TILE_W-2:0], 1'b0}; // msb goes out now
                2'b01:   sreg <= {sreg[TILE_W-2:0], 1'b0};    // toward msb
                default: sreg <= sreg;                        // hold
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            held_col <= color; // colour ram sampled with pattern
        end
    end

    // on load the ram msb bypasses the register
    assign sout    = load ? pattern[TILE_W-1] : sreg[TILE_W-1];
    assign cur_col = load ? color : held_col;
    assign pix_d   = sout ? cur_col : '0; // clear bit shows colour 0

    ////////////////////////////////////////////////////////////
    // 273 output latch

    always_ff @(posedge clk or negedge cl_b) begin
        if (!cl_b) begin
            pixel <= '0;
        end else begin
            pixel <= pix_d; // beam position plus 2
        end
    end

endmodule

`default_nettype wire

/* rtl/vram_arbiter.sv */
`default_nettype none

module vram_arbiter import ttl_pkg::*, board_pkg::*; (
    input  wire byte_t      h_cnt,    // beam column
    input  wire nibble_t    v_cnt,    // beam line
    input  wire logic       vblank,   // cpu owns the rams
    input  wire tile_addr_t cpu_addr, // cpu tile address
    input  wire logic       cpu_we,   // cpu write request level
    output ram_addr_t       ram_addr, // shared 2016 address
    output logic            ram_we,   // shared 2016 write strobe
    output logic            cpu_wait  // stall back to cpu
);

    tile_addr_t vid_addr;   // tile under the beam
    logic       cpu_sel;    // 157 select pin
    ram_addr_t  cpu_wide;   // a side of the mux
    ram_addr_t  vid_wide;   // b side of the mux

    ////////////////////////////////////////////////////////////
    // video address, one tile per 8 clocks

    // column is h_cnt / TILE_W within the line
    assign vid_addr = {v_cnt, h_cnt[5:3]};

    // upper 2016 pins tied low on this board
    assign cpu_wide = ram_addr_t'(cpu_addr);
    assign vid_wide = ram_addr_t'(vid_addr);

    ////////////////////////////////////////////////////////////
    // 157 mux, strobe tied active

    assign cpu_sel  = vblank;                         // cpu only in vblank
    assign ram_addr = cpu_sel ? cpu_wide : vid_wide;

    ////////////////////////////////////////////////////////////
    // write gating and wait

    // write lands on the first vblank edge with we up
    assign ram_we = cpu_we & cpu_sel;

    // stall while the video side owns the address
    assign cpu_wait = cpu_we & ~cpu_sel;

endmodule

`default_nettype wire

/* rtl/video_timing.sv */
`default_nettype none

module video_timing import ttl_pkg::*, board_pkg::*; (
    input  wire logic clk,
    input  wire logic cl_b,   // board reset
    output byte_t     h_cnt,  // pixel clock count in line
    output nibble_t   v_cnt,  // line count in frame
    output logic      hsync,
    output logic      hblank,
    output logic      vblank
);

    nibble_t h_lo;            // low horizontal chip
    nibble_t h_hi;            // high horizontal chip
    logic    ca_lo;           // ripple carry lo to hi
    logic    h_wrap;          // last clock of the line
    logic    v_wrap;          // last clock of the frame
    logic    h_ld_b;          // shared preset of both h chips
    logic    v_ld_b;

    ////////////////////////////////////////////////////////////
    // horizontal chain, two 161s

    assign h_cnt  = {h_hi, h_lo};
    assign h_wrap = (h_cnt == byte_t'(H_TOTAL - 1)); // terminal count decode
    assign h_ld_b = ~h_wrap;                          // preset to zero

    ttl_161 u_h_lo (
        .clk  (clk),
        .cl_b (cl_b),
        .ld_b (h_ld_b),
        .cep  (1'b1),          // free running
        .cet  (1'b1),
        .d    (nibble_t'(0)),
        .q    (h_lo),
        .ca   (ca_lo)
    );

    ttl_161 u_h_hi (
        .clk  (clk),
        .cl_b (cl_b),
        .ld_b (h_ld_b),
        .cep  (1'b1),
        .cet  (ca_lo),         // steps on lo rollover
        .d    (nibble_t'(0)),
        .q    (h_hi),
        .ca   ()               // no third stage
    );

    ////////////////////////////////////////////////////////////
    // vertical chip, stepped once per line

    assign v_wrap = h_wrap & (v_cnt == nibble_t'(V_TOTAL - 1));
    assign v_ld_b = ~v_wrap;

    ttl_161 u_v (
        .clk  (clk),
        .cl_b (cl_b),
        .ld_b (v_ld_b),
        .cep  (h_wrap),        // line wrap enables count
        .cet  (1'b1),
        .d    (nibble_t'(0)),
        .q    (v_cnt),
        .ca   ()
    );

    ////////////////////////////////////////////////////////////
    // window decode, straight off the counters

    assign hblank = (h_cnt >= byte_t'(H_VISIBLE));   // right border onward
    assign hsync  = (h_cnt >= byte_t'(HSYNC_START)) &&
                    (h_cnt <  byte_t'(HSYNC_END));   // 4 clocks inside hblank
    assign vblank = (v_cnt >= nibble_t'(V_VISIBLE)); // bottom lines

endmodule

`default_nettype wire

/* rtl/ttl_2016.sv */
`default_nettype none

module ttl_2016 import ttl_pkg::*; #(
    parameter type data_t = byte_t  // word stored per address
) (
    input  wire logic      clk,
    input  wire ram_addr_t addr,    // from the 157 mux
    input  wire logic      we,      // write strobe, high active
    input  wire data_t     wdata,   // cpu side data
    output data_t          rdata    // video side data
);

    data_t mem [RAM_DEPTH];         // cell array

    ////////////////////////////////////////////////////////////
    // write port

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;     // cpu write
        end
    end

    ////////////////////////////////////////////////////////////
    // read port, held in an output register

    always_ff @(posedge clk) begin
        rdata <= mem[addr];         // valid one clock after addr
    end

    // old word on a same-cycle write

endmodule

`default_nettype wire

/* rtl/ttl_161.sv */
`default_nettype none

module ttl_161 import ttl_pkg::*; (
    input  wire logic    clk,  // cp, rising edge
    input  wire logic    cl_b, // master reset, async
    input  wire logic    ld_b, // parallel enable, sync
    input  wire logic    cep,  // count enable parallel
    input  wire logic    cet,  // count enable trickle
    input  wire nibble_t d,    // preset data
    output nibble_t      q,    // counter outputs
    output logic         ca    // terminal count
);

    // carry only with trickle enable, so chips cascade
    assign ca = &{q, cet};

    always_ff @(posedge clk or negedge cl_b) begin
        if (!cl_b) begin
            q <= '0;              // clear overrides all
        end else if (!ld_b) begin
            q <= d;               // preset wins over count
        end else if (cep && cet) begin
            q <= q + 4'd1;        // both enables needed
        end
    end

    // hold otherwise

endmodule

`default_nettype wire

/* rtl/board_pkg.sv */
`default_nettype none

package board_pkg;

    ////////////////////////////////////////////////////////////
    // raster, shrunk for simulation

    localparam int H_TOTAL     = 64; // clocks per line
    localparam int H_VISIBLE   = 48; // six tiles across
    localparam int HSYNC_START = 52; // first sync clock
    localparam int HSYNC_END   = 56; // first clock after sync

    localparam int V_TOTAL   = 16; // lines per frame
    localparam int V_VISIBLE = 12; // lines before vblank

    ////////////////////////////////////////////////////////////
    // tile fetch

    localparam int TILE_W        = 8; // pixels per pattern byte
    localparam int PIXEL_LATENCY = 2; // beam position to pixel pin

    typedef logic [6:0] tile_addr_t; // {line[3:0], column[2:0]}
    typedef logic [7:0] pattern_t;   // msb is leftmost pixel
    typedef logic [3:0] color_t;     // palette index

    ////////////////////////////////////////////////////////////

endpackage

`default_nettype wire

/* rtl/ttl_pkg.sv */
`default_nettype none

package ttl_pkg;

    ////////////////////////////////////////////////////////////
    // pin-group widths of the 74-series and memory parts

    typedef logic [3:0]  nibble_t;   // one 161 counter or 157 slice
    typedef logic [7:0]  byte_t;     // octal parts, 273 and friends

    // 2016 static ram, 2k words
    typedef logic [10:0] ram_addr_t; // a10..a0

    localparam int RAM_DEPTH = 2048; // words per 2016

    ////////////////////////////////////////////////////////////

endpackage

`default_nettype wire
